/* list.f */
armPkg.sv
alu.sv
regFile.sv
condUnit.sv
decoder.sv
hazardUnit.sv
datapath.sv
armCore.sv
armCore_assert.sv
armCore_tb.sv

/* armCore_tb.sv */
// Testbench for armCore with a random program checked store by store against an in-order model
`timescale 1ns/10ps
`default_nettype none

module armCore_tb;

   import armPkg::*;

   localparam int progLen       = 200;   // Random part of the program
   localparam int imemWords     = 512;
   localparam int dmemWords     = 16;
   localparam int timeoutCycles = 3000;
   localparam int drainCycles   = 20;

   logic                 clk;
   logic                 reset;
   logic [dataWidth-1:0] InstrF, ReadDataM, PCF, ALUOutM, WriteDataM;
   logic                 MemWriteM;

   logic [dataWidth-1:0] imem [imemWords];
   logic [dataWidth-1:0] dmem [dmemWords];

   // Reference model state
   logic [dataWidth-1:0] mRegs [16];
   logic [dataWidth-1:0] mMem  [dmemWords];
   logic                 mN, mZ, mC, mV;
   logic [dataWidth-1:0] expAddr [$];
   logic [dataWidth-1:0] expData [$];

   logic [31:0]          rngState;
   logic [dataWidth-1:0] prevPC;

   armCore u_dut (
      .clk(clk), .reset(reset), .InstrF(InstrF), .ReadDataM(ReadDataM),
      .PCF(PCF), .MemWriteM(MemWriteM), .ALUOutM(ALUOutM), .WriteDataM(WriteDataM)
   );

   always #2 clk = ~clk;

   assign InstrF    = imem[PCF[10:2]];
   assign ReadDataM = dmem[ALUOutM[5:2]];  // Combinational data memory

   function automatic logic [31:0] nextRandom();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   function automatic logic [3:0] destReg(input logic [3:0] pick);
      return 4'(1 + pick % 14);  // R1 to R14
   endfunction

   // ARM condition codes on the model flags
   function automatic logic condPasses(input logic [3:0] cond);
      case (cond)
         4'h0: return mZ;
         4'h1: return !mZ;
         4'h2: return mC;
         4'h3: return !mC;
         4'h4: return mN;
         4'h5: return !mN;
         4'h6: return mV;
         4'h7: return !mV;
         4'h8: return mC && !mZ;
         4'h9: return !mC || mZ;
         4'hA: return mN == mV;
         4'hB: return mN != mV;
         4'hC: return !mZ && (mN == mV);
         4'hD: return mZ || (mN != mV);
         4'hE: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   task automatic modelDataProc(input instrWord_t w);
      logic [dataWidth-1:0] a, b, res;
      logic [dataWidth:0]   wide;
      longint               exact;
      logic                 cOut, vOut, arith;
      a     = mRegs[w.dpView.rn];
      b     = w.dpView.immFlag ? {24'b0, w.dpView.immOrRm} : mRegs[w.dpView.immOrRm[3:0]];
      exact = 0;
      cOut  = 1'b0;
      arith = 1'b1;
      case (w.dpView.funct)
         funcAdd:
         begin
            res   = a + b;
            wide  = {1'b0, a} + {1'b0, b};
            cOut  = wide[dataWidth];
            exact = longint'($signed(a)) + longint'($signed(b));
         end
         funcSub:
         begin
            res   = a - b;
            cOut  = (a >= b);  // Carry set when no borrow
            exact = longint'($signed(a)) - longint'($signed(b));
         end
         funcAnd:
         begin
            res   = a & b;
            arith = 1'b0;
         end
         default:
         begin
            res   = a | b;
            arith = 1'b0;
         end
      endcase
      vOut = arith && (exact != longint'($signed(res)));  // Result did not fit
      if (condPasses(w.dpView.cond))
      begin
         mRegs[w.dpView.rd] = res;
         if (w.dpView.sBit)
         begin
            mN = res[dataWidth-1];
            mZ = (res == '0);
            if (arith)
            begin
               mC = cOut;
               mV = vOut;
            end
         end
      end
   endtask

   task automatic modelMemory(input instrWord_t w);
      logic [dataWidth-1:0] addr;
      addr = mRegs[w.memView.rn] + {20'b0, w.memView.offset};
      if (condPasses(w.memView.cond))
      begin
         if (w.memView.load)
            mRegs[w.memView.rd] = mMem[addr[5:2]];
         else
         begin
            mMem[addr[5:2]] = mRegs[w.memView.rd];
            expAddr.push_back(addr);
            expData.push_back(mRegs[w.memView.rd]);
         end
      end
   endtask

   // Fills both memories and runs the model over the program as it is built
   task automatic buildProgram();
      instrWord_t  w;
      logic [31:0] r;
      int          pc;
      for (int i = 0; i < imemWords; i++)
         imem[i] = {condNever, 28'b0};
      for (int i = 0; i < dmemWords; i++)
      begin
         dmem[i] = 32'h9E3779B9 * (i + 1);
         mMem[i] = dmem[i];
      end
      for (int i = 0; i < 16; i++)
         mRegs[i] = '0;
      {mN, mZ, mC, mV} = 4'b0000;
      // Decode already holds word 0 when reset ends, so start after two idle words
      pc = 2;
      for (int k = 0; k < progLen; k++)
      begin
         r = nextRandom();
         w = '0;
         if (r[2:0] < 3'd5)
         begin
            w.dpView.cond    = r[3] ? condAlways : r[7:4];
            w.dpView.op      = opDataProc;
            w.dpView.immFlag = r[8];
            case (r[10:9])
               2'd0:    w.dpView.funct = funcAdd;
               2'd1:    w.dpView.funct = funcSub;
               2'd2:    w.dpView.funct = funcAnd;
               default: w.dpView.funct = funcOrr;
            endcase
            w.dpView.sBit    = r[11];
            w.dpView.rn      = r[15:12];
            w.dpView.rd      = destReg(r[19:16]);
            w.dpView.immOrRm = r[8] ? r[27:20] : {4'b0, r[23:20]};
            modelDataProc(w);
         end
         else
         begin
            w.memView.cond   = r[3] ? condAlways : r[7:4];
            w.memView.op     = opMemory;
            w.memView.pubw   = 4'b1100;  // Pre-indexed, offset added
            w.memView.load   = r[8];
            w.memView.rn     = 4'd0;     // R0 is never written
            w.memView.rd     = destReg(r[19:16]);
            w.memView.offset = {6'b0, r[23:20], 2'b00};
            modelMemory(w);
         end
         imem[pc] = w;
         pc++;
      end
      // Dump the final register values
      for (int i = 1; i <= 14; i++)
      begin
         w = '0;
         w.memView.cond   = condAlways;
         w.memView.op     = opMemory;
         w.memView.pubw   = 4'b1100;
         w.memView.rd     = 4'(i);
         w.memView.offset = 12'(4 * i);
         modelMemory(w);
         imem[pc] = w;
         pc++;
      end
   endtask

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("sim failed");
   endtask

   // Stores are taken and checked midcycle, where the memory-stage outputs are stable
   always @(negedge clk)
   begin
      if (!reset)
      begin
         assert (!$isunknown(MemWriteM))
         else
         begin
            reportFailure("MemWriteM went unknown after reset");
            $fatal(1);
         end
         assert (PCF == prevPC || PCF == prevPC + 32'd4)
         else
         begin
            reportFailure($sformatf("error: pc step expected %h or %h actual %h",
                                    prevPC, prevPC + 32'd4, PCF));
            $fatal(1);
         end
         if (MemWriteM)
         begin
            assert (expAddr.size() > 0)
            else
            begin
               reportFailure("The core stored more words than the model expects");
               $fatal(1);
            end
            assert (ALUOutM == expAddr[0])
            else
            begin
               reportFailure($sformatf("error: store address expected %h actual %h",
                                       expAddr[0], ALUOutM));
               $fatal(1);
            end
            assert (WriteDataM == expData[0])
            else
            begin
               reportFailure($sformatf("error: store data expected %h actual %h",
                                       expData[0], WriteDataM));
               $fatal(1);
            end
            dmem[ALUOutM[5:2]] = WriteDataM;
            void'(expAddr.pop_front());
            void'(expData.pop_front());
         end
      end
      prevPC = PCF;
   end

   initial
   begin
      int waited;
      clk        = 1'b0;
      reset      = 1'b1;
      rngState   = 32'd17;
      prevPC     = '0;
      buildProgram();
      // PC and store enable held at zero through every reset cycle
      for (int i = 0; i < 16; i++)
      begin
         @(posedge clk);
         #1;
         assert (PCF == '0 && MemWriteM == 1'b0)
         else
         begin
            reportFailure(
               $sformatf("error: reset state expected pc 0 store 0 actual pc %h store %b",
                         PCF, MemWriteM));
            $fatal(1);
         end
      end
      reset = 1'b0;
      for (int i = 1; i <= 3; i++)
      begin
         @(posedge clk);
         #1;
         assert (PCF == 32'(4 * i))
         else
         begin
            reportFailure($sformatf("error: first fetches expected %h actual %h",
                                    32'(4 * i), PCF));
            $fatal(1);
         end
      end
      waited = 0;
      while (expAddr.size() > 0 && waited < timeoutCycles)
      begin
         @(posedge clk);
         waited++;
      end
      if (expAddr.size() > 0)
      begin
         reportFailure($sformatf("Timed out with %0d stores still missing", expAddr.size()));
         $fatal(1);
      end
      // Watch for stray stores past the end of the program
      waited = 0;
      while (waited < drainCycles)
      begin
         @(posedge clk);
         waited++;
      end
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

/* armCore_assert.sv */
// Concurrent port checks, bound into every armCore instance
`timescale 1ns/10ps
`default_nettype none

module armCore_assert (
   input logic                         clk,
   input logic                         reset,
   input logic [armPkg::dataWidth-1:0] PCF,
   input logic                         MemWriteM
);

   memWriteKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(MemWriteM))
      else $error("MemWriteM is unknown");

   // No branches, so fetch only holds or steps one word
   pcStep: assert property (@(posedge clk) disable iff (reset)
      (PCF == $past(PCF)) || (PCF == $past(PCF) + 32'd4))
      else $error("PCF neither held nor advanced by 4");

   pcReset: assert property (@(posedge clk) reset |-> (PCF == '0))
      else $error("PCF is not zero during reset");

endmodule

bind armCore armCore_assert u_assert (
   .clk(clk), .reset(reset), .PCF(PCF), .MemWriteM(MemWriteM)
);

`default_nettype wire

/* armCore.sv */
// Top of the five-stage pipelined core; connect it to instruction and data memories
`timescale 1ns/10ps
`default_nettype none

module armCore (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [armPkg::dataWidth-1:0] InstrF,
   input  logic [armPkg::dataWidth-1:0] ReadDataM,
   output logic [armPkg::dataWidth-1:0] PCF,
   output logic                         MemWriteM,
   output logic [armPkg::dataWidth-1:0] ALUOutM,
   output logic [armPkg::dataWidth-1:0] WriteDataM
);

   import armPkg::*;

   instrWord_t InstrD;
   logic       ImmSrcD, RegSrcD;
   logic       ALUSrcE;
   logic [1:0] ALUControlE, FlagWriteE;
   logic [3:0] CondE, ALUFlagsE;
   logic       CondExE;
   logic       MemtoRegE, RegWriteM, MemtoRegW, RegWriteW;
   logic [1:0] ForwardAE, ForwardBE;
   logic       StallF, StallD, FlushE;
   logic       Match1EM, Match1EW, Match2EM, Match2EW, Match12DE;

   decoder decode (
      .clk(clk), .reset(reset), .InstrD(InstrD), .FlushE(FlushE), .CondExE(CondExE),
      .ImmSrcD(ImmSrcD), .RegSrcD(RegSrcD), .ALUSrcE(ALUSrcE), .ALUControlE(ALUControlE),
      .FlagWriteE(FlagWriteE), .CondE(CondE), .MemtoRegE(MemtoRegE),
      .RegWriteM(RegWriteM), .MemWriteM(MemWriteM), .MemtoRegW(MemtoRegW),
      .RegWriteW(RegWriteW)
   );

   condUnit cond (
      .clk(clk), .reset(reset), .CondE(CondE), .FlagWriteE(FlagWriteE),
      .ALUFlagsE(ALUFlagsE), .CondExE(CondExE)
   );

   hazardUnit hazard (
      .Match1EM(Match1EM), .Match1EW(Match1EW), .Match2EM(Match2EM),
      .Match2EW(Match2EW), .Match12DE(Match12DE), .RegWriteM(RegWriteM),
      .RegWriteW(RegWriteW), .MemtoRegE(MemtoRegE), .ForwardAE(ForwardAE),
      .ForwardBE(ForwardBE), .StallF(StallF), .StallD(StallD), .FlushE(FlushE)
   );

   datapath dp (
      .clk(clk), .reset(reset), .InstrF(InstrF), .ReadDataM(ReadDataM),
      .ImmSrcD(ImmSrcD), .RegSrcD(RegSrcD), .ALUSrcE(ALUSrcE), .ALUControlE(ALUControlE),
      .MemtoRegW(MemtoRegW), .RegWriteW(RegWriteW), .ForwardAE(ForwardAE),
      .ForwardBE(ForwardBE), .StallF(StallF), .StallD(StallD), .FlushE(FlushE),
      .PCF(PCF), .InstrD(InstrD), .ALUOutM(ALUOutM), .WriteDataM(WriteDataM),
      .ALUFlagsE(ALUFlagsE), .Match1EM(Match1EM), .Match1EW(Match1EW),
      .Match2EM(Match2EM), .Match2EW(Match2EW), .Match12DE(Match12DE)
   );

endmodule

`default_nettype wire

/* datapath.sv */
// PC, pipeline data registers, register file, operand forwarding and result select
`timescale 1ns/10ps
`default_nettype none

module datapath (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [armPkg::dataWidth-1:0] InstrF,
   input  logic [armPkg::dataWidth-1:0] ReadDataM,
   input  logic                         ImmSrcD,
   input  logic                         RegSrcD,
   input  logic                         ALUSrcE,
   input  logic [1:0]                   ALUControlE,
   input  logic                         MemtoRegW,
   input  logic                         RegWriteW,
   input  logic [1:0]                   ForwardAE,
   input  logic [1:0]                   ForwardBE,
   input  logic                         StallF,
   input  logic                         StallD,
   input  logic                         FlushE,
   output logic [armPkg::dataWidth-1:0] PCF,
   output armPkg::instrWord_t           InstrD,
   output logic [armPkg::dataWidth-1:0] ALUOutM,
   output logic [armPkg::dataWidth-1:0] WriteDataM,
   output logic [3:0]                   ALUFlagsE,
   output logic                         Match1EM,
   output logic                         Match1EW,
   output logic                         Match2EM,
   output logic                         Match2EW,
   output logic                         Match12DE
);

   import armPkg::*;

   logic [dataWidth-1:0]    PCPlus4F;
   logic [dataWidth-1:0]    rd1D, rd2D, ExtImmD;
   logic [dataWidth-1:0]    rd1E, rd2E, ExtImmE;
   logic [dataWidth-1:0]    SrcAE, SrcBE, WriteDataE, ALUResultE;
   logic [dataWidth-1:0]    ALUOutW, ReadDataW, ResultW;
   logic [regAddrWidth-1:0] RA1D, RA2D, RA1E, RA2E;
   logic [regAddrWidth-1:0] WA3E, WA3M, WA3W;

   // Fetch
   assign PCPlus4F = PCF + dataWidth'(4);

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         PCF <= '0;
      else if (!StallF)
         PCF <= PCPlus4F;
   end

   // Decode
   always_ff @(posedge clk)
   begin
      if (!StallD)
         InstrD <= InstrF;
   end

   assign RA1D = InstrD.dpView.rn;
   assign RA2D = RegSrcD ? InstrD.dpView.rd : InstrD.dpView.immOrRm[regAddrWidth-1:0];
   assign ExtImmD = ImmSrcD ? {{(dataWidth-12){1'b0}}, InstrD.memView.offset}
                            : {{(dataWidth-8){1'b0}}, InstrD.dpView.immOrRm};

   regFile rf (
      .clk(clk), .reset(reset), .writeEnable(RegWriteW),
      .readAddr1(RA1D), .readAddr2(RA2D), .writeAddr(WA3W), .writeData(ResultW),
      .readData1(rd1D), .readData2(rd2D)
   );

   // Execute; a flushed slot carries an all-zero bubble
   always_ff @(posedge clk)
   begin
      if (FlushE)
      begin
         rd1E    <= '0;
         rd2E    <= '0;
         ExtImmE <= '0;
         RA1E    <= '0;
         RA2E    <= '0;
         WA3E    <= '0;
      end
      else
      begin
         rd1E    <= rd1D;
         rd2E    <= rd2D;
         ExtImmE <= ExtImmD;
         RA1E    <= RA1D;
         RA2E    <= RA2D;
         WA3E    <= InstrD.dpView.rd;
      end
   end

   always_comb
   begin
      case (ForwardAE)
         fwdMemory:    SrcAE = ALUOutM;
         fwdWriteback: SrcAE = ResultW;
         default:      SrcAE = rd1E;
      endcase
      case (ForwardBE)
         fwdMemory:    WriteDataE = ALUOutM;
         fwdWriteback: WriteDataE = ResultW;
         default:      WriteDataE = rd2E;
      endcase
   end

   assign SrcBE = ALUSrcE ? ExtImmE : WriteDataE;

   alu arith (
      .a(SrcAE), .b(SrcBE), .ALUControl(ALUControlE),
      .Result(ALUResultE), .Flags(ALUFlagsE)
   );

   // Memory and writeback
   always_ff @(posedge clk)
   begin
      ALUOutM    <= ALUResultE;
      WriteDataM <= WriteDataE;
      WA3M       <= WA3E;
      ALUOutW    <= ALUOutM;
      ReadDataW  <= ReadDataM;
      WA3W       <= WA3M;
   end

   assign ResultW = MemtoRegW ? ReadDataW : ALUOutW;

   // Register number compares for forwarding and the load-use check
   assign Match1EM  = (WA3M == RA1E);
   assign Match1EW  = (WA3W == RA1E);
   assign Match2EM  = (WA3M == RA2E);
   assign Match2EW  = (WA3W == RA2E);
   assign Match12DE = (WA3E == RA1D) | (WA3E == RA2D);

endmodule

`default_nettype wire

/* hazardUnit.sv */
// Forwarding selects and the load-use stall for the pipeline
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
   input  logic       Match1EM,
   input  logic       Match1EW,
   input  logic       Match2EM,
   input  logic       Match2EW,
   input  logic       Match12DE,
   input  logic       RegWriteM,
   input  logic       RegWriteW,
   input  logic       MemtoRegE,
   output logic [1:0] ForwardAE,
   output logic [1:0] ForwardBE,
   output logic       StallF,
   output logic       StallD,
   output logic       FlushE
);

   import armPkg::*;

   logic ldrStall;

   // Memory stage holds the newer value, so it wins
   assign ForwardAE = (Match1EM & RegWriteM) ? fwdMemory
                    : (Match1EW & RegWriteW) ? fwdWriteback : fwdRegFile;
   assign ForwardBE = (Match2EM & RegWriteM) ? fwdMemory
                    : (Match2EW & RegWriteW) ? fwdWriteback : fwdRegFile;

   // Load result not ready until writeback; hold fetch and decode one cycle
   assign ldrStall = Match12DE & MemtoRegE;
   assign StallF   = ldrStall;
   assign StallD   = ldrStall;
   assign FlushE   = ldrStall;  // Bubble into execute

endmodule

`default_nettype wire

/* decoder.sv */
// Instruction decode and the control pipeline from execute through writeback
`timescale 1ns/10ps
`default_nettype none

module decoder (
   input  logic               clk,
   input  logic               reset,
   input  armPkg::instrWord_t InstrD,
   input  logic               FlushE,
   input  logic               CondExE,
   output logic               ImmSrcD,
   output logic               RegSrcD,
   output logic               ALUSrcE,
   output logic [1:0]         ALUControlE,
   output logic [1:0]         FlagWriteE,
   output logic [3:0]         CondE,
   output logic               MemtoRegE,
   output logic               RegWriteM,
   output logic               MemWriteM,
   output logic               MemtoRegW,
   output logic               RegWriteW
);

   import armPkg::*;

   logic       ALUSrcD, MemtoRegD, RegWriteD, MemWriteD;
   logic [1:0] ALUControlD, FlagWriteD;
   logic       RegWriteE, MemWriteE, MemtoRegM;

   always_comb
   begin
      ImmSrcD     = 1'b0;
      RegSrcD     = 1'b0;
      ALUSrcD     = 1'b0;
      MemtoRegD   = 1'b0;
      RegWriteD   = 1'b0;
      MemWriteD   = 1'b0;
      ALUControlD = aluAdd;  // Address add for loads and stores
      FlagWriteD  = 2'b00;
      case (InstrD.dpView.op)
         opDataProc:
         begin
            ALUSrcD   = InstrD.dpView.immFlag;
            RegWriteD = 1'b1;
            case (InstrD.dpView.funct)
               funcSub: ALUControlD = aluSub;
               funcAnd: ALUControlD = aluAnd;
               funcOrr: ALUControlD = aluOrr;
               default: ALUControlD = aluAdd;
            endcase
            // NZ on any S, CV only from the adder
            FlagWriteD[1] = InstrD.dpView.sBit;
            FlagWriteD[0] = InstrD.dpView.sBit & ~ALUControlD[1];
         end
         opMemory:
         begin
            ImmSrcD   = 1'b1;                   // 12-bit offset
            RegSrcD   = ~InstrD.memView.load;   // Store data comes from Rd
            ALUSrcD   = 1'b1;
            MemtoRegD = InstrD.memView.load;
            RegWriteD = InstrD.memView.load;
            MemWriteD = ~InstrD.memView.load;
         end
         default: ;  // Other ops decode to a no-op
      endcase
   end

   // Execute stage; a flush turns the slot into a bubble
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         {ALUSrcE, ALUControlE, CondE} <= '0;
         {RegWriteE, MemWriteE, MemtoRegE, FlagWriteE} <= '0;
      end
      else
      begin
         ALUSrcE     <= ALUSrcD;
         ALUControlE <= ALUControlD;
         CondE       <= InstrD.dpView.cond;
         if (FlushE)
            {RegWriteE, MemWriteE, MemtoRegE, FlagWriteE} <= '0;
         else
            {RegWriteE, MemWriteE, MemtoRegE, FlagWriteE} <=
               {RegWriteD, MemWriteD, MemtoRegD, FlagWriteD};
      end
   end

   // Memory and writeback stages, writes gated by the condition
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
      begin
         {RegWriteM, MemWriteM, MemtoRegM} <= '0;
         {RegWriteW, MemtoRegW} <= '0;
      end
      else
      begin
         RegWriteM <= RegWriteE & CondExE;
         MemWriteM <= MemWriteE & CondExE;
         MemtoRegM <= MemtoRegE;
         RegWriteW <= RegWriteM;
         MemtoRegW <= MemtoRegM;
      end
   end

endmodule

`default_nettype wire

/* condUnit.sv */
// NZCV status register with condition check for the instruction in execute
`timescale 1ns/10ps
`default_nettype none

module condUnit (
   input  logic       clk,
   input  logic       reset,
   input  logic [3:0] CondE,
   input  logic [1:0] FlagWriteE,
   input  logic [3:0] ALUFlagsE,
   output logic       CondExE
);

   import armPkg::*;

   logic neg, zero, carry, overflow;
   logic ge;

   assign ge = (neg == overflow);

   always_comb
   begin
      case (CondE)
         4'b0000:    CondExE = zero;               // EQ
         4'b0001:    CondExE = ~zero;              // NE
         4'b0010:    CondExE = carry;              // CS
         4'b0011:    CondExE = ~carry;             // CC
         4'b0100:    CondExE = neg;                // MI
         4'b0101:    CondExE = ~neg;               // PL
         4'b0110:    CondExE = overflow;           // VS
         4'b0111:    CondExE = ~overflow;          // VC
         4'b1000:    CondExE = carry & ~zero;      // HI
         4'b1001:    CondExE = ~carry | zero;      // LS
         4'b1010:    CondExE = ge;                 // GE
         4'b1011:    CondExE = ~ge;                // LT
         4'b1100:    CondExE = ~zero & ge;         // GT
         4'b1101:    CondExE = zero | ~ge;         // LE
         condAlways: CondExE = 1'b1;
         condNever:  CondExE = 1'b0;
      endcase
   end

   // Skipped instructions leave the flags alone
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         {neg, zero, carry, overflow} <= 4'b0000;
      else
      begin
         if (FlagWriteE[1] && CondExE)
            {neg, zero} <= ALUFlagsE[3:2];
         if (FlagWriteE[0] && CondExE)
            {carry, overflow} <= ALUFlagsE[1:0];
      end
   end

endmodule

`default_nettype wire

/* regFile.sv */
// Sixteen-entry register file, two combinational reads and a falling-edge write
`timescale 1ns/10ps
`default_nettype none

module regFile (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            writeEnable,
   input  logic [armPkg::regAddrWidth-1:0] readAddr1,
   input  logic [armPkg::regAddrWidth-1:0] readAddr2,
   input  logic [armPkg::regAddrWidth-1:0] writeAddr,
   input  logic [armPkg::dataWidth-1:0]    writeData,
   output logic [armPkg::dataWidth-1:0]    readData1,
   output logic [armPkg::dataWidth-1:0]    readData2
);

   import armPkg::*;

   logic [dataWidth-1:0] regs [2**regAddrWidth];

   // Midcycle write so decode sees the writeback value in the same cycle
   always_ff @(negedge clk, posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < 2**regAddrWidth; i++)
            regs[i] <= '0;
      end
      else if (writeEnable)
         regs[writeAddr] <= writeData;
   end

   assign readData1 = regs[readAddr1];
   assign readData2 = regs[readAddr2];

endmodule

`default_nettype wire

/* alu.sv */
// Add, subtract, AND and OR with NZCV generation for the execute stage
`timescale 1ns/10ps
`default_nettype none

module alu (
   input  logic [armPkg::dataWidth-1:0] a,
   input  logic [armPkg::dataWidth-1:0] b,
   input  logic [1:0]                   ALUControl,
   output logic [armPkg::dataWidth-1:0] Result,
   output logic [3:0]                   Flags
);

   import armPkg::*;

   logic                 isSub, isArith;
   logic [dataWidth-1:0] bInv;
   logic [dataWidth:0]   sum;   // Top bit is the carry out

   assign isSub   = (ALUControl == aluSub);
   assign isArith = (ALUControl == aluAdd) | isSub;
   assign bInv    = isSub ? ~b : b;
   assign sum     = {1'b0, a} + {1'b0, bInv} + {{dataWidth{1'b0}}, isSub};

   always_comb
   begin
      case (ALUControl)
         aluAnd:  Result = a & b;
         aluOrr:  Result = a | b;
         default: Result = sum[dataWidth-1:0];
      endcase
   end

   // Subtract carry set means no borrow
   assign Flags[3] = Result[dataWidth-1];
   assign Flags[2] = (Result == '0);
   assign Flags[1] = isArith & sum[dataWidth];
   assign Flags[0] = isArith & (a[dataWidth-1] == bInv[dataWidth-1])
                     & (sum[dataWidth-1] != a[dataWidth-1]);

endmodule

`default_nettype wire

/* armPkg.sv */
// Shared widths, opcode, ALU, condition and forwarding codes, and the instruction word views
`default_nettype none

package armPkg;

   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 4;

   // Op field, Instr[27:26]
   localparam logic [1:0] opDataProc = 2'b00;
   localparam logic [1:0] opMemory   = 2'b01;

   // ALU control; bit 1 set means a logic operation
   localparam logic [1:0] aluAdd = 2'b00;
   localparam logic [1:0] aluSub = 2'b01;
   localparam logic [1:0] aluAnd = 2'b10;
   localparam logic [1:0] aluOrr = 2'b11;

   // Function field, Instr[24:21]
   localparam logic [3:0] funcAdd = 4'b0100;
   localparam logic [3:0] funcSub = 4'b0010;
   localparam logic [3:0] funcAnd = 4'b0000;
   localparam logic [3:0] funcOrr = 4'b1100;

   localparam logic [3:0] condAlways = 4'b1110;
   localparam logic [3:0] condNever  = 4'b1111; // Reserved code, never executes

   // Execute operand source
   localparam logic [1:0] fwdRegFile   = 2'b00;
   localparam logic [1:0] fwdWriteback = 2'b01;
   localparam logic [1:0] fwdMemory    = 2'b10;

   // One instruction word, seen as data processing or as load/store
   typedef union packed {
      struct packed {
         logic [3:0] cond;
         logic [1:0] op;
         logic       immFlag;  // 1 for immediate operand
         logic [3:0] funct;
         logic       sBit;
         logic [3:0] rn;
         logic [3:0] rd;
         logic [3:0] rot;      // Always zero in this subset
         logic [7:0] immOrRm;  // Rm sits in the low nibble
      } dpView;
      struct packed {
         logic [3:0]  cond;
         logic [1:0]  op;
         logic        regOffset;
         logic [3:0]  pubw;
         logic        load;
         logic [3:0]  rn;
         logic [3:0]  rd;
         logic [11:0] offset;
      } memView;
   } instrWord_t;

endpackage

`default_nettype wire
